// ==== hdl/ooo_pkg.sv ====
package ooo_pkg;

    //////////////////////////////
    // operation codes
    //////////////////////////////

    // integer unit takes the first four
    // multiplier takes OP_MUL only
    typedef enum logic [2:0] {
        OP_ADD = 3'd0,
        OP_SUB = 3'd1,
        OP_AND = 3'd2,
        OP_XOR = 3'd3,
        OP_MUL = 3'd4
    } op_t;

    //////////////////////////////
    // sizes
    //////////////////////////////

    // default data width
    localparam int XLEN_DEFAULT = 16;

    // default reorder buffer entries
    localparam int ROB_DEPTH_DEFAULT = 4;

    // architectural register file
    localparam int REG_NUM = 8;
    localparam int REG_IDX_W = 3;

endpackage

// ==== hdl/int_unit.sv ====
`timescale 1ns/100ps

module int_unit #(
    parameter int xlen = ooo_pkg::XLEN_DEFAULT,
    parameter int rob_depth = ooo_pkg::ROB_DEPTH_DEFAULT
) (
    input  logic                         clock,
    input  logic                         arst_n,
    input  logic                         alu_issue,
    input  ooo_pkg::op_t                 issue_op,
    input  logic [xlen-1:0]              issue_a,
    input  logic [xlen-1:0]              issue_b,
    input  logic [$clog2(rob_depth)-1:0] issue_tag,
    output logic                         alu_done,
    output logic [$clog2(rob_depth)-1:0] alu_tag,
    output logic [xlen-1:0]              alu_result
);
    import ooo_pkg::*;

    logic [xlen-1:0] alu_next;

    // single-cycle operation select, wraps modulo 2^xlen
    always_comb begin
        case (issue_op)
            OP_ADD:  alu_next = issue_a + issue_b;
            OP_SUB:  alu_next = issue_a - issue_b;
            OP_AND:  alu_next = issue_a & issue_b;
            OP_XOR:  alu_next = issue_a ^ issue_b;
            default: alu_next = '0;
        endcase
    end

    // done pulse, one cycle after issue
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            alu_done <= 1'b0;
        end else begin
            alu_done <= alu_issue;
        end
    end

    // result and tag captured with the issue
    always_ff @(posedge clock) begin
        if (alu_issue) begin
            alu_tag    <= issue_tag;
            alu_result <= alu_next;
        end
    end

endmodule

// ==== hdl/mul_control.sv ====
`timescale 1ns/100ps

module mul_control #(
    parameter int rob_depth = ooo_pkg::ROB_DEPTH_DEFAULT,
    parameter int xlen = ooo_pkg::XLEN_DEFAULT
) (
    input  logic                         clock,
    input  logic                         arst_n,
    input  logic                         mul_issue,
    input  logic [$clog2(rob_depth)-1:0] issue_tag,
    input  logic                         mul_grant,
    input  logic                         last_step,
    output logic                         step_load,
    output logic                         step_en,
    output logic [$clog2(xlen)-1:0]      step_init,
    output logic                         mul_busy,
    output logic                         mul_done,
    output logic [$clog2(rob_depth)-1:0] mul_tag
);

    typedef enum logic [1:0] {
        s_idle,
        s_busy,
        s_done
    } state_t;

    state_t state, state_next;

    // xlen steps, counter runs from xlen-1 down to zero
    assign step_init = $clog2(xlen)'(xlen - 1);

    always_comb begin
        state_next = state;
        case (state)
            s_idle:  if (mul_issue) state_next = s_busy;
            s_busy:  if (last_step) state_next = s_done;
            // hold result until the buffer takes it
            s_done:  if (mul_grant) state_next = s_idle;
            default: state_next = s_idle;
        endcase
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state <= s_idle;
        end else begin
            state <= state_next;
        end
    end

    // tag travels with the operation
    always_ff @(posedge clock) begin
        if (step_load) begin
            mul_tag <= issue_tag;
        end
    end

    // datapath and counter steering
    assign step_load = (state == s_idle) && mul_issue;
    assign step_en   = (state == s_busy);
    // busy covers the done wait as well
    assign mul_busy  = (state != s_idle);
    assign mul_done  = (state == s_done);

endmodule

// ==== hdl/mul_step_counter.sv ====
`timescale 1ns/100ps

module mul_step_counter #(
    parameter int xlen = ooo_pkg::XLEN_DEFAULT
) (
    input  logic                    clock,
    input  logic                    arst_n,
    input  logic                    step_load,
    input  logic                    step_en,
    input  logic [$clog2(xlen)-1:0] step_init,
    output logic                    last_step
);

    logic [$clog2(xlen)-1:0] count;

    // load on issue, count down while stepping
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            count <= '0;
        end else if (step_load) begin
            count <= step_init;
        end else if (step_en && count != '0) begin
            count <= count - 1'b1;
        end
    end

    // zero marks the final shift-add step
    assign last_step = (count == '0);

endmodule

// ==== hdl/mul_datapath.sv ====
`timescale 1ns/100ps

module mul_datapath #(
    parameter int xlen = ooo_pkg::XLEN_DEFAULT
) (
    input  logic            clock,
    input  logic            arst_n,
    input  logic            step_load,
    input  logic            step_en,
    input  logic [xlen-1:0] issue_a,
    input  logic [xlen-1:0] issue_b,
    output logic [xlen-1:0] mul_result
);

    //////////////////////////////
    // shift-add registers
    //////////////////////////////

    logic [xlen-1:0] mcand;
    logic [xlen-1:0] mplier;
    logic [xlen-1:0] product;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            mcand   <= '0;
            mplier  <= '0;
            product <= '0;
        end else if (step_load) begin
            // fresh operands, cleared sum
            mcand   <= issue_a;
            mplier  <= issue_b;
            product <= '0;
        end else if (step_en) begin
            // add when low multiplier bit set
            if (mplier[0]) begin
                product <= product + mcand;
            end
            // upper product bits drop out here
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

    // low xlen bits only
    assign mul_result = product;

endmodule

// ==== hdl/reorder_buffer.sv ====
`timescale 1ns/100ps

module reorder_buffer #(
    parameter int xlen = ooo_pkg::XLEN_DEFAULT,
    parameter int rob_depth = ooo_pkg::ROB_DEPTH_DEFAULT
) (
    input  logic                             clock,
    input  logic                             arst_n,
    input  logic                             issue_valid,
    input  ooo_pkg::op_t                     issue_op,
    input  logic [ooo_pkg::REG_IDX_W-1:0]    issue_dest,
    input  logic                             mul_busy,
    output logic                             issue_stall,
    output logic                             alu_issue,
    output logic                             mul_issue,
    output logic [$clog2(rob_depth)-1:0]     issue_tag,
    input  logic                             alu_done,
    input  logic [$clog2(rob_depth)-1:0]     alu_tag,
    input  logic [xlen-1:0]                  alu_result,
    input  logic                             mul_done,
    input  logic [$clog2(rob_depth)-1:0]     mul_tag,
    input  logic [xlen-1:0]                  mul_result,
    output logic                             mul_grant,
    output logic                             commit_valid,
    output logic [ooo_pkg::REG_IDX_W-1:0]    commit_dest,
    output logic [xlen-1:0]                  commit_data,
    output logic [$clog2(rob_depth)-1:0]     commit_tag
);
    import ooo_pkg::*;

    localparam int tag_w = $clog2(rob_depth);
    localparam int cnt_w = $clog2(rob_depth + 1);

    // entry storage
    logic [REG_IDX_W-1:0] dest_q [rob_depth];
    logic [xlen-1:0]      value_q [rob_depth];
    logic [rob_depth-1:0] done_q;

    logic [tag_w-1:0] head;
    logic [tag_w-1:0] tail;
    logic [cnt_w-1:0] count;

    logic             full;
    logic             accept;
    logic             cpl_valid;
    logic [tag_w-1:0] cpl_tag;
    logic [xlen-1:0]  cpl_value;

    // circular increment, depth need not be a power of two
    function automatic logic [tag_w-1:0] ptr_next(input logic [tag_w-1:0] ptr);
        if (ptr == tag_w'(rob_depth - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    //////////////////////////////
    // dispatch
    //////////////////////////////

    assign full = (count == cnt_w'(rob_depth));

    // single multiplier, so a second multiply waits
    assign issue_stall = full || (issue_op == OP_MUL && mul_busy);
    assign accept      = issue_valid && !issue_stall;

    // exactly one unit gets the accepted operation
    assign alu_issue = accept && (issue_op != OP_MUL);
    assign mul_issue = accept && (issue_op == OP_MUL);
    assign issue_tag = tail;

    //////////////////////////////
    // completion select
    //////////////////////////////

    // integer unit first, it cannot hold its result
    assign mul_grant = mul_done && !alu_done;
    assign cpl_valid = alu_done || mul_done;
    assign cpl_tag   = alu_done ? alu_tag : mul_tag;
    assign cpl_value = alu_done ? alu_result : mul_result;

    //////////////////////////////
    // retire
    //////////////////////////////

    // oldest entry leaves once finished
    assign commit_valid = (count != '0) && done_q[head];
    assign commit_dest  = dest_q[head];
    assign commit_data  = value_q[head];
    assign commit_tag   = head;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            head   <= '0;
            tail   <= '0;
            count  <= '0;
            done_q <= '0;
        end else begin
            if (accept) begin
                tail         <= ptr_next(tail);
                done_q[tail] <= 1'b0;
            end
            // completion never targets the free tail slot
            if (cpl_valid) begin
                done_q[cpl_tag] <= 1'b1;
            end
            if (commit_valid) begin
                head <= ptr_next(head);
            end
            count <= count + cnt_w'(accept) - cnt_w'(commit_valid);
        end
    end

    // destination at dispatch, value at completion
    always_ff @(posedge clock) begin
        if (accept) begin
            dest_q[tail] <= issue_dest;
        end
        if (cpl_valid) begin
            value_q[cpl_tag] <= cpl_value;
        end
    end

endmodule

// ==== hdl/register_file.sv ====
`timescale 1ns/100ps

module register_file #(
    parameter int xlen = ooo_pkg::XLEN_DEFAULT
) (
    input  logic                                     clock,
    input  logic                                     arst_n,
    input  logic                                     commit_valid,
    input  logic [ooo_pkg::REG_IDX_W-1:0]            commit_dest,
    input  logic [xlen-1:0]                          commit_data,
    output logic [ooo_pkg::REG_NUM-1:0][xlen-1:0]    registers
);

    //////////////////////////////
    // architectural state
    //////////////////////////////

    // written only at retire, so always in program order
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            registers <= '0;
        end else if (commit_valid) begin
            registers[commit_dest] <= commit_data;
        end
    end

    // every register visible at the port
    // no read ports, operands come with the operation

endmodule

// ==== hdl/ooo_core.sv ====
`timescale 1ns/100ps

module ooo_core #(
    parameter int xlen = ooo_pkg::XLEN_DEFAULT,
    parameter int rob_depth = ooo_pkg::ROB_DEPTH_DEFAULT
) (
    input  logic                                  clock,
    input  logic                                  arst_n,
    input  logic                                  issue_valid,
    input  ooo_pkg::op_t                          issue_op,
    input  logic [ooo_pkg::REG_IDX_W-1:0]         issue_dest,
    input  logic [xlen-1:0]                       issue_a,
    input  logic [xlen-1:0]                       issue_b,
    output logic                                  issue_stall,
    output logic                                  commit_valid,
    output logic [ooo_pkg::REG_IDX_W-1:0]         commit_dest,
    output logic [xlen-1:0]                       commit_data,
    output logic [$clog2(rob_depth)-1:0]          commit_tag,
    output logic [ooo_pkg::REG_NUM-1:0][xlen-1:0] registers
);

    localparam int tag_w = $clog2(rob_depth);

    // issue side
    logic             alu_issue;
    logic             mul_issue;
    logic [tag_w-1:0] issue_tag;

    // completion side
    logic             alu_done;
    logic [tag_w-1:0] alu_tag;
    logic [xlen-1:0]  alu_result;
    logic             mul_done;
    logic [tag_w-1:0] mul_tag;
    logic [xlen-1:0]  mul_result;
    logic             mul_grant;
    logic             mul_busy;

    // multiplier steering
    logic                    step_load;
    logic                    step_en;
    logic                    last_step;
    logic [$clog2(xlen)-1:0] step_init;

    //////////////////////////////
    // execution units
    //////////////////////////////

    int_unit #(.xlen(xlen), .rob_depth(rob_depth)) u_int_unit (
        .clock, .arst_n, .alu_issue, .issue_op, .issue_a, .issue_b, .issue_tag,
        .alu_done, .alu_tag, .alu_result
    );

    mul_control #(.rob_depth(rob_depth), .xlen(xlen)) u_mul_control (
        .clock, .arst_n, .mul_issue, .issue_tag, .mul_grant, .last_step,
        .step_load, .step_en, .step_init, .mul_busy, .mul_done, .mul_tag
    );

    mul_step_counter #(.xlen(xlen)) u_mul_step_counter (
        .clock, .arst_n, .step_load, .step_en, .step_init, .last_step
    );

    mul_datapath #(.xlen(xlen)) u_mul_datapath (
        .clock, .arst_n, .step_load, .step_en, .issue_a, .issue_b, .mul_result
    );

    //////////////////////////////
    // ordering and state
    //////////////////////////////

    reorder_buffer #(.xlen(xlen), .rob_depth(rob_depth)) u_reorder_buffer (
        .clock, .arst_n, .issue_valid, .issue_op, .issue_dest, .mul_busy,
        .issue_stall, .alu_issue, .mul_issue, .issue_tag,
        .alu_done, .alu_tag, .alu_result, .mul_done, .mul_tag, .mul_result,
        .mul_grant, .commit_valid, .commit_dest, .commit_data, .commit_tag
    );

    register_file #(.xlen(xlen)) u_register_file (
        .clock, .arst_n, .commit_valid, .commit_dest, .commit_data, .registers
    );

endmodule

// ==== test/ooo_core_props.sv ====
`timescale 1ns/100ps

module ooo_core_props #(
    parameter int rob_depth = ooo_pkg::ROB_DEPTH_DEFAULT
) (
    input logic         clock,
    input logic         arst_n,
    input logic         issue_valid,
    input ooo_pkg::op_t issue_op,
    input logic         issue_stall,
    input logic         commit_valid
);
    import ooo_pkg::*;

    localparam int occ_w = $clog2(rob_depth + 1);

    // entries in flight, seen from the ports only
    logic [occ_w-1:0] occupancy;

    // failure tally, read by the testbench
    int unsigned fail_count = 0;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            occupancy <= '0;
        end else begin
            occupancy <= occupancy + occ_w'(issue_valid && !issue_stall)
                         - occ_w'(commit_valid);
        end
    end

    //////////////////////////////
    // dispatch rules
    //////////////////////////////

    // one multiplier, a second multiply has to wait
    mul_waits: assert property (@(posedge clock) disable iff (!arst_n)
        (issue_valid && issue_op == OP_MUL && ooo_core.mul_busy) |-> issue_stall)
        else begin
            fail_count++;
            $error("multiply offered to a busy multiplier was not stalled");
        end

    // no free entry, nothing gets in
    full_stalls: assert property (@(posedge clock) disable iff (!arst_n)
        (occupancy == occ_w'(rob_depth)) |-> issue_stall)
        else begin
            fail_count++;
            $error("reorder buffer full but dispatch not stalled");
        end

    //////////////////////////////
    // reset rules
    //////////////////////////////

    // quiet while held in reset
    reset_quiet: assert property (@(posedge clock)
        !arst_n |-> (!commit_valid && !issue_stall))
        else begin
            fail_count++;
            $error("commit or stall active during reset");
        end

    // and on the first edge out of it
    release_quiet: assert property (@(posedge clock)
        $rose(arst_n) |-> (!commit_valid && !issue_stall))
        else begin
            fail_count++;
            $error("commit or stall active right after reset");
        end

endmodule

// ==== test/ooo_core_tb.sv ====
`timescale 1ns/100ps

module ooo_core_tb;
    import ooo_pkg::*;

    localparam int xlen = XLEN_DEFAULT;
    localparam int rob_depth = ROB_DEPTH_DEFAULT;
    localparam int tag_w = $clog2(rob_depth);
    localparam int op_count = 60;
    localparam int stall_limit = 200;
    localparam int drain_limit = 500;

    logic                         clock;
    logic                         arst_n;
    logic                         issue_valid;
    op_t                          issue_op;
    logic [REG_IDX_W-1:0]         issue_dest;
    logic [xlen-1:0]              issue_a;
    logic [xlen-1:0]              issue_b;
    logic                         issue_stall;
    logic                         commit_valid;
    logic [REG_IDX_W-1:0]         commit_dest;
    logic [xlen-1:0]              commit_data;
    logic [tag_w-1:0]             commit_tag;
    logic [REG_NUM-1:0][xlen-1:0] registers;

    // reference model, oldest accepted op at the front
    logic [xlen-1:0]      exp_data [$];
    logic [REG_IDX_W-1:0] exp_dest [$];
    logic [xlen-1:0]      model_regs [REG_NUM];
    logic [tag_w-1:0]     exp_tag;
    logic [31:0]          rng_state;
    int                   mismatches;
    int                   errors;
    bit                   timed_out;

    ooo_core DUT (
        .clock, .arst_n, .issue_valid, .issue_op, .issue_dest, .issue_a, .issue_b,
        .issue_stall, .commit_valid, .commit_dest, .commit_data, .commit_tag, .registers
    );

    bind ooo_core ooo_core_props #(.rob_depth(rob_depth)) props (
        .clock, .arst_n, .issue_valid, .issue_op, .issue_stall, .commit_valid
    );

    always #50 clock = ~clock;

    //////////////////////////////
    // helpers
    //////////////////////////////

    function automatic logic [31:0] lcg_step(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // arithmetic wraps at xlen bits
    function automatic logic [xlen-1:0] expected_result(input op_t op,
            input logic [xlen-1:0] a, input logic [xlen-1:0] b);
        logic [xlen-1:0] r;
        case (op)
            OP_ADD:  r = a + b;
            OP_SUB:  r = a - b;
            OP_AND:  r = a & b;
            OP_XOR:  r = a ^ b;
            OP_MUL:  r = a * b;
            default: r = '0;
        endcase
        return r;
    endfunction

    // called on a falling edge, returns on a falling edge
    task automatic dispatch(input op_t op, input logic [REG_IDX_W-1:0] dest,
            input logic [xlen-1:0] a, input logic [xlen-1:0] b);
        int waited;
        bit taken;
        waited = 0;
        taken = 1'b0;
        issue_valid = 1'b1;
        issue_op = op;
        issue_dest = dest;
        issue_a = a;
        issue_b = b;
        // op held until an edge without stall
        while (!taken && waited < stall_limit) begin
            @(posedge clock);
            if (!issue_stall) begin
                taken = 1'b1;
                exp_data.push_back(expected_result(op, a, b));
                exp_dest.push_back(dest);
            end else begin
                waited++;
            end
        end
        if (!taken) begin
            $display("timeout: operation stalled for %0d cycles and never accepted", waited);
            errors++;
            timed_out = 1'b1;
        end
        @(negedge clock);
        issue_valid = 1'b0;
    endtask

    task automatic dispatch_random();
        op_t op;
        logic [REG_IDX_W-1:0] dest;
        logic [xlen-1:0] a;
        rng_state = lcg_step(rng_state);
        // top bit picks multiply half the time, so bursts happen
        op = rng_state[18] ? OP_MUL : op_t'({1'b0, rng_state[17:16]});
        dest = rng_state[21:19];
        // occasional idle cycle
        if (rng_state[23:22] == 2'b11) begin
            @(negedge clock);
        end
        rng_state = lcg_step(rng_state);
        a = rng_state[8 +: xlen];
        rng_state = lcg_step(rng_state);
        dispatch(op, dest, a, rng_state[8 +: xlen]);
    endtask

    //////////////////////////////
    // commit checks
    //////////////////////////////

    task automatic check_commit();
        assert (exp_data.size() != 0) else begin
            errors++;
            $display("commit seen with no operation outstanding");
        end
        if (exp_data.size() != 0) begin
            assert (commit_data == exp_data[0]) else begin
                mismatches++;
                $display("MISMATCH commit_data expected %h got %h", exp_data[0], commit_data);
            end
            assert (commit_dest == exp_dest[0]) else begin
                mismatches++;
                $display("MISMATCH commit_dest expected %h got %h", exp_dest[0], commit_dest);
            end
            assert (commit_tag == exp_tag) else begin
                mismatches++;
                $display("MISMATCH commit_tag expected %h got %h", exp_tag, commit_tag);
            end
            model_regs[exp_dest[0]] = exp_data[0];
            void'(exp_data.pop_front());
            void'(exp_dest.pop_front());
            // tags wrap at rob_depth
            exp_tag = (exp_tag == tag_w'(rob_depth - 1)) ? '0 : tag_w'(exp_tag + 1);
        end
    endtask

    always @(posedge clock) begin
        if (arst_n && commit_valid) begin
            check_commit();
        end
    end

    task automatic end_run();
        int failures;
        failures = mismatches + errors + int'(DUT.props.fail_count);
        $display("mismatches %0d, other errors %0d, assertion failures %0d",
                 mismatches, errors, DUT.props.fail_count);
        if (failures == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    endtask

    //////////////////////////////
    // main sequence
    //////////////////////////////

    initial begin
        int waited;
        clock = 1'b0;
        arst_n = 1'b0;
        issue_valid = 1'b0;
        issue_op = OP_ADD;
        issue_dest = '0;
        issue_a = '0;
        issue_b = '0;
        rng_state = 32'h74cb;
        exp_tag = '0;
        mismatches = 0;
        errors = 0;
        timed_out = 1'b0;
        waited = 0;
        for (int i = 0; i < REG_NUM; i++) begin
            model_regs[i] = '0;
        end
        repeat (8) @(posedge clock);
        @(negedge clock);
        arst_n = 1'b1;

        // slow multiply at the head, integer ops fill the rest
        dispatch(OP_MUL, 3'd1, 16'h0123, 16'h0045);
        dispatch(OP_ADD, 3'd2, 16'hfff0, 16'h0021);
        dispatch(OP_SUB, 3'd3, 16'h0004, 16'h0009);
        dispatch(OP_XOR, 3'd4, 16'ha5a5, 16'h0ff0);
        // full buffer and busy multiplier both hold these
        dispatch(OP_MUL, 3'd5, 16'hbeef, 16'h1234);
        dispatch(OP_MUL, 3'd6, 16'h8001, 16'hffff);
        dispatch(OP_AND, 3'd1, 16'hf0f0, 16'h3c3c);

        for (int n = 0; n < op_count && !timed_out; n++) begin
            dispatch_random();
        end

        // drain outstanding commits
        while (exp_data.size() != 0 && waited < drain_limit) begin
            @(negedge clock);
            waited++;
        end
        if (exp_data.size() != 0) begin
            $display("timeout: %0d operations never committed", exp_data.size());
            errors++;
        end
        @(negedge clock);

        for (int i = 0; i < REG_NUM; i++) begin
            assert (registers[i] == model_regs[i]) else begin
                mismatches++;
                $display("MISMATCH registers[%0d] expected %h got %h",
                         i, model_regs[i], registers[i]);
            end
        end
        end_run();
    end

endmodule

// ==== files.f ====
hdl/ooo_pkg.sv
hdl/int_unit.sv
hdl/mul_control.sv
hdl/mul_step_counter.sv
hdl/mul_datapath.sv
hdl/reorder_buffer.sv
hdl/register_file.sv
hdl/ooo_core.sv
test/ooo_core_props.sv
test/ooo_core_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= ooo_core_tb
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert

SRCS := $(shell cat $(FILELIST))
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf $(OBJ_DIR)
